// ==== design/cpu_settings.svh ====
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

`define DATA_W 32
`define REG_ADDR_W 5
`define RESET_PC 32'h0000_0000

`define OPCODE_F 31:26
`define BNE_BIT 26
`define RS_F 25:21
`define RT_F 20:16
`define RD_F 15:11
`define SHAMT_F 10:6
`define FUNCT_F 5:0
`define IMM_F 15:0
`define TARGET_F 25:0

`endif

// ==== design/cpuPkg.sv ====
package cpuPkg;

        typedef enum logic [5:0] {
                OP_RTYPE = 6'h00,
                OP_J     = 6'h02,
                OP_BEQ   = 6'h04,
                OP_BNE   = 6'h05,
                OP_ADDIU = 6'h09,
                OP_LW    = 6'h23,
                OP_SW    = 6'h2b
        } opcodeT;

        typedef enum logic [5:0] {
                FN_SLL  = 6'h00,
                FN_ADDU = 6'h21,
                FN_SUBU = 6'h23,
                FN_AND  = 6'h24,
                FN_OR   = 6'h25,
                FN_SLT  = 6'h2a
        } functT;

        typedef enum logic [2:0] {
                ALU_ADD,
                ALU_SUB,
                ALU_AND,
                ALU_OR,
                ALU_SLT,
                ALU_SHL
        } aluOpT;

        typedef enum logic [3:0] {
                S_FETCH,
                S_DECODE,
                S_MEMADDR,
                S_MEMREAD,
                S_LOADWB,
                S_STORE,
                S_REXEC,
                S_SHIFTEXEC,
                S_RWB,
                S_BRANCH,
                S_JUMP,
                S_IMMEXEC,
                S_IMMWB
        } cpuStateT;

        typedef enum logic [1:0] {A_PC, A_REGA, A_REGB} aSrcT;

        typedef enum logic [2:0] {B_REGB, B_FOUR, B_SIGNIMM, B_SHIFTIMM, B_SHAMT} bSrcT;

        typedef enum logic [1:0] {PC_ALURESULT, PC_ALUOUT, PC_JUMP} pcSrcT;

        typedef enum logic {WB_ALUOUT, WB_MDR} wbSrcT;

        typedef enum logic {RD_RT, RD_RD} regDstT;

endpackage

// ==== design/regFile.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module regFile (
        input  logic                   clk,
        input  logic                   rst,
        input  logic [`REG_ADDR_W-1:0] readAddrA,
        input  logic [`REG_ADDR_W-1:0] readAddrB,
        input  logic [`REG_ADDR_W-1:0] writeAddr,
        input  logic                   writeEnable,
        input  logic [`DATA_W-1:0]     writeValue,
        output logic [`DATA_W-1:0]     readValueA,
        output logic [`DATA_W-1:0]     readValueB
);

        logic [`DATA_W-1:0] regs [0:(1 << `REG_ADDR_W)-1];

        always_ff @(posedge clk)
        begin
                if (rst)
                begin
                        for (int i = 0; i < (1 << `REG_ADDR_W); i++)
                        begin
                                regs[i] <= '0;
                        end
                end
                else if (writeEnable && writeAddr != '0) // r0 stays zero
                begin
                        regs[writeAddr] <= writeValue;
                end
        end

        assign readValueA = (readAddrA == '0) ? '0 : regs[readAddrA];
        assign readValueB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule

// ==== design/aluUnit.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module aluUnit import cpuPkg::*; (
        input  logic [`DATA_W-1:0] operandA,
        input  logic [`DATA_W-1:0] operandB,
        input  aluOpT              op,
        output logic [`DATA_W-1:0] result,
        output logic               zero
);

        always_comb
        begin
                case (op)
                        ALU_ADD:
                        begin
                                result = operandA + operandB; // wraps
                        end
                        ALU_SUB:
                        begin
                                result = operandA - operandB;
                        end
                        ALU_AND:
                        begin
                                result = operandA & operandB;
                        end
                        ALU_OR:
                        begin
                                result = operandA | operandB;
                        end
                        ALU_SLT:
                        begin
                                result = `DATA_W'($signed(operandA) < $signed(operandB));
                        end
                        ALU_SHL:
                        begin
                                // rt value arrives on A, shamt on B
                                result = operandA << operandB[4:0];
                        end
                        default:
                        begin
                                result = '0;
                        end
                endcase
        end

        assign zero = (result == '0);

endmodule

// ==== design/controlFsm.sv ====
`timescale 1ns/1ps

module controlFsm import cpuPkg::*; (
        input  logic   clk,
        input  logic   rst,
        input  opcodeT opcode,
        input  functT  funct,
        input  logic   branchTaken,
        output aSrcT   aSrc,
        output bSrcT   bSrc,
        output aluOpT  aluOp,
        output pcSrcT  pcSrc,
        output wbSrcT  wbSrc,
        output regDstT regDst,
        output logic   pcEnable,
        output logic   irWrite,
        output logic   regWrite,
        output logic   instrRead,
        output logic   memRead,
        output logic   memWrite
);

        cpuStateT state;
        cpuStateT nextState;
        logic     pcWrite;
        logic     pcWriteCond;

        always_ff @(posedge clk)
        begin
                if (rst)
                begin
                        state <= S_FETCH;
                end
                else
                begin
                        state <= nextState;
                end
        end

        always_comb
        begin
                case (state)
                        S_FETCH:     nextState = S_DECODE;
                        S_DECODE:
                        begin
                                case (opcode)
                                        OP_RTYPE: nextState = (funct == FN_SLL) ? S_SHIFTEXEC : S_REXEC;
                                        OP_BEQ,
                                        OP_BNE:   nextState = S_BRANCH;
                                        OP_J:     nextState = S_JUMP;
                                        OP_ADDIU: nextState = S_IMMEXEC;
                                        OP_LW,
                                        OP_SW:    nextState = S_MEMADDR;
                                        default:  nextState = S_FETCH; // unknown opcode skipped
                                endcase
                        end
                        S_MEMADDR:   nextState = (opcode == OP_LW) ? S_MEMREAD : S_STORE;
                        S_MEMREAD:   nextState = S_LOADWB;
                        S_REXEC,
                        S_SHIFTEXEC: nextState = S_RWB;
                        S_IMMEXEC:   nextState = S_IMMWB;
                        default:     nextState = S_FETCH;
                endcase
        end

        always_comb
        begin
                aSrc        = A_PC;
                bSrc        = B_REGB;
                aluOp       = ALU_ADD;
                pcSrc       = PC_ALURESULT;
                wbSrc       = WB_ALUOUT;
                regDst      = RD_RT;
                pcWrite     = 1'b0;
                pcWriteCond = 1'b0;
                irWrite     = 1'b0;
                regWrite    = 1'b0;
                instrRead   = 1'b0;
                memRead     = 1'b0;
                memWrite    = 1'b0;
                case (state)
                        S_FETCH:
                        begin
                                bSrc      = B_FOUR; // pc + 4
                                pcWrite   = 1'b1;
                                irWrite   = 1'b1;
                                instrRead = 1'b1;
                        end
                        S_DECODE:
                        begin
                                bSrc = B_SHIFTIMM; // branch target into ALUOut
                        end
                        S_MEMADDR, S_MEMREAD, S_STORE:
                        begin
                                aSrc     = A_REGA; // keeps ALUOut steady
                                bSrc     = B_SIGNIMM;
                                memRead  = (state == S_MEMREAD);
                                memWrite = (state == S_STORE);
                        end
                        S_LOADWB:
                        begin
                                wbSrc    = WB_MDR;
                                regWrite = 1'b1;
                        end
                        S_REXEC:
                        begin
                                aSrc = A_REGA;
                                case (funct)
                                        FN_SUBU: aluOp = ALU_SUB;
                                        FN_AND:  aluOp = ALU_AND;
                                        FN_OR:   aluOp = ALU_OR;
                                        FN_SLT:  aluOp = ALU_SLT;
                                        default: aluOp = ALU_ADD;
                                endcase
                        end
                        S_SHIFTEXEC:
                        begin
                                aSrc  = A_REGB;
                                bSrc  = B_SHAMT;
                                aluOp = ALU_SHL;
                        end
                        S_RWB:
                        begin
                                regDst   = RD_RD;
                                regWrite = 1'b1;
                        end
                        S_BRANCH:
                        begin
                                aSrc        = A_REGA;
                                aluOp       = ALU_SUB; // compare rs with rt
                                pcSrc       = PC_ALUOUT;
                                pcWriteCond = 1'b1;
                        end
                        S_JUMP:
                        begin
                                pcSrc   = PC_JUMP;
                                pcWrite = 1'b1;
                        end
                        S_IMMEXEC:
                        begin
                                aSrc = A_REGA;
                                bSrc = B_SIGNIMM;
                        end
                        S_IMMWB:
                        begin
                                regWrite = 1'b1;
                        end
                        default:
                        begin
                                pcWrite = 1'b0;
                        end
                endcase
        end

        assign pcEnable = pcWrite | (pcWriteCond & branchTaken);

endmodule

// ==== design/datapath.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module datapath import cpuPkg::*; (
        input  logic               clk,
        input  logic               rst,
        input  aSrcT               aSrc,
        input  bSrcT               bSrc,
        input  aluOpT              aluOp,
        input  pcSrcT              pcSrc,
        input  wbSrcT              wbSrc,
        input  regDstT             regDst,
        input  logic               pcEnable,
        input  logic               irWrite,
        input  logic               regWrite,
        input  logic [`DATA_W-1:0] instruction,
        input  logic [`DATA_W-1:0] readData,
        output logic [`DATA_W-1:0] pc,
        output logic [`DATA_W-1:0] dataAddr,
        output logic [`DATA_W-1:0] writeData,
        output opcodeT             opcode,
        output functT              funct,
        output logic               branchTaken
);

        logic [`DATA_W-1:0]     ir;
        logic [`DATA_W-1:0]     regA;
        logic [`DATA_W-1:0]     regB;
        logic [`DATA_W-1:0]     aluOut;
        logic [`DATA_W-1:0]     mdr;
        logic [`DATA_W-1:0]     readValueA;
        logic [`DATA_W-1:0]     readValueB;
        logic [`DATA_W-1:0]     signImm;
        logic [`DATA_W-1:0]     jumpTarget;
        logic [`DATA_W-1:0]     operandA;
        logic [`DATA_W-1:0]     operandB;
        logic [`DATA_W-1:0]     aluResult;
        logic [`DATA_W-1:0]     nextPc;
        logic [`DATA_W-1:0]     writeValue;
        logic [`REG_ADDR_W-1:0] writeAddr;
        logic                   zero;

        always_ff @(posedge clk)
        begin
                if (rst)
                begin
                        pc <= `RESET_PC;
                end
                else if (pcEnable)
                begin
                        pc <= nextPc;
                end
        end

        // temporaries follow their sources every cycle
        always_ff @(posedge clk)
        begin
                if (irWrite)
                begin
                        ir <= instruction;
                end
                regA   <= readValueA;
                regB   <= readValueB;
                aluOut <= aluResult;
                mdr    <= readData;
        end

        assign signImm    = `DATA_W'(signed'(ir[`IMM_F]));
        assign jumpTarget = {pc[`DATA_W-1:`DATA_W-4], ir[`TARGET_F], 2'b00}; // upper bits of pc + 4

        always_comb
        begin
                case (aSrc)
                        A_REGA:  operandA = regA;
                        A_REGB:  operandA = regB;
                        default: operandA = pc;
                endcase
                case (bSrc)
                        B_FOUR:     operandB = `DATA_W'(4);
                        B_SIGNIMM:  operandB = signImm;
                        B_SHIFTIMM: operandB = signImm << 2;
                        B_SHAMT:    operandB = `DATA_W'(ir[`SHAMT_F]);
                        default:    operandB = regB;
                endcase
                case (pcSrc)
                        PC_ALUOUT: nextPc = aluOut;
                        PC_JUMP:   nextPc = jumpTarget;
                        default:   nextPc = aluResult;
                endcase
        end

        assign writeAddr  = (regDst == RD_RD) ? ir[`RD_F] : ir[`RT_F];
        assign writeValue = (wbSrc == WB_MDR) ? mdr : aluOut;

        regFile i_regFile (
                .clk        (clk),
                .rst        (rst),
                .readAddrA  (ir[`RS_F]),
                .readAddrB  (ir[`RT_F]),
                .writeAddr  (writeAddr),
                .writeEnable(regWrite),
                .writeValue (writeValue),
                .readValueA (readValueA),
                .readValueB (readValueB)
        );

        aluUnit i_aluUnit (
                .operandA(operandA),
                .operandB(operandB),
                .op      (aluOp),
                .result  (aluResult),
                .zero    (zero)
        );

        assign opcode      = opcodeT'(ir[`OPCODE_F]);
        assign funct       = functT'(ir[`FUNCT_F]);
        assign branchTaken = ir[`BNE_BIT] ? ~zero : zero; // bne inverts the compare
        assign dataAddr    = aluOut;
        assign writeData   = regB;

endmodule

// ==== design/mipsCpu.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module mipsCpu import cpuPkg::*; (
        input  logic               clk,
        input  logic               rst,
        output logic [`DATA_W-1:0] pc,
        output logic               instrRead,
        input  logic [`DATA_W-1:0] instruction,
        output logic [`DATA_W-1:0] dataAddr,
        output logic [`DATA_W-1:0] writeData,
        input  logic [`DATA_W-1:0] readData,
        output logic               memRead,
        output logic               memWrite
);

        aSrcT   aSrc;
        bSrcT   bSrc;
        aluOpT  aluOp;
        pcSrcT  pcSrc;
        wbSrcT  wbSrc;
        regDstT regDst;
        opcodeT opcode;
        functT  funct;
        logic   branchTaken;
        logic   pcEnable;
        logic   irWrite;
        logic   regWrite;

        controlFsm i_controlFsm (
                .clk        (clk),
                .rst        (rst),
                .opcode     (opcode),
                .funct      (funct),
                .branchTaken(branchTaken),
                .aSrc       (aSrc),
                .bSrc       (bSrc),
                .aluOp      (aluOp),
                .pcSrc      (pcSrc),
                .wbSrc      (wbSrc),
                .regDst     (regDst),
                .pcEnable   (pcEnable),
                .irWrite    (irWrite),
                .regWrite   (regWrite),
                .instrRead  (instrRead),
                .memRead    (memRead),
                .memWrite   (memWrite)
        );

        datapath i_datapath (
                .clk        (clk),
                .rst        (rst),
                .aSrc       (aSrc),
                .bSrc       (bSrc),
                .aluOp      (aluOp),
                .pcSrc      (pcSrc),
                .wbSrc      (wbSrc),
                .regDst     (regDst),
                .pcEnable   (pcEnable),
                .irWrite    (irWrite),
                .regWrite   (regWrite),
                .instruction(instruction),
                .readData   (readData),
                .pc         (pc),
                .dataAddr   (dataAddr),
                .writeData  (writeData),
                .opcode     (opcode),
                .funct      (funct),
                .branchTaken(branchTaken)
        );

endmodule

// ==== verif/mipsCpu_checker.sv ====
`timescale 1ns/1ps

module mipsCpu_checker import cpuPkg::*; (
        input logic     clk,
        input logic     rst,
        input logic     instrRead,
        input logic     memRead,
        input logic     memWrite,
        input logic     regWrite,
        input cpuStateT state
);

        memExclusive: assert property (@(posedge clk) disable iff (rst)
                !(memRead && memWrite))
        else $error("memRead and memWrite are high in the same cycle");

        fetchOnly: assert property (@(posedge clk) disable iff (rst)
                instrRead |-> state == S_FETCH)
        else $error("instrRead is high outside the FETCH state");

        // write-back never overlaps fetch or decode
        noEarlyWrite: assert property (@(posedge clk) disable iff (rst)
                (state == S_FETCH || state == S_DECODE) |-> !regWrite)
        else $error("regWrite is high in FETCH or DECODE");

endmodule

bind controlFsm mipsCpu_checker i_mipsCpuChecker (
        .clk      (clk),
        .rst      (rst),
        .instrRead(instrRead),
        .memRead  (memRead),
        .memWrite (memWrite),
        .regWrite (regWrite),
        .state    (state)
);

// ==== verif/mipsCpu_tb.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module mipsCpu_tb import cpuPkg::*; ();

        localparam int PROG_LEN     = 64;
        localparam int DATA_WORDS   = 64;
        localparam int RESET_CYCLES = 16;
        localparam int MAX_CYCLES   = 1000; // 64 x 5 cycles plus reset, with margin
        localparam int LOOP_FETCHES = 3;
        localparam logic [31:0] SEED = 32'h8c19_0b5d;
        localparam logic [`DATA_W-1:0] FINAL_PC = `DATA_W'((PROG_LEN - 1) * 4);

        logic               clk;
        logic               rst;
        logic [`DATA_W-1:0] pc;
        logic               instrRead;
        logic [`DATA_W-1:0] instruction;
        logic [`DATA_W-1:0] dataAddr;
        logic [`DATA_W-1:0] writeData;
        logic [`DATA_W-1:0] readData;
        logic               memRead;
        logic               memWrite;

        logic [`DATA_W-1:0] instrMem [0:PROG_LEN-1];
        logic [`DATA_W-1:0] dataMem [0:DATA_WORDS-1];
        logic [`DATA_W-1:0] modelMem [0:DATA_WORDS-1];
        logic [`DATA_W-1:0] modelRegs [0:31];
        logic [`DATA_W-1:0] modelPc;
        logic [`DATA_W-1:0] storeAddrQ [$];
        logic [`DATA_W-1:0] storeDataQ [$];
        logic [`DATA_W-1:0] loadAddrQ [$];
        logic [31:0]        lfsrState;
        logic               runDone = 1'b0;
        int                 cycleCount = 0;
        int                 runCycle = 0;
        int                 lastFetchCycle = 0;
        int                 fetchCount = 0;
        int                 expectedGap = 0;
        int                 loopFetches = 0;
        int                 storeCount = 0;
        int                 modelStoreCount = 0;

        mipsCpu i_mipsCpu (
                .clk        (clk),
                .rst        (rst),
                .pc         (pc),
                .instrRead  (instrRead),
                .instruction(instruction),
                .dataAddr   (dataAddr),
                .writeData  (writeData),
                .readData   (readData),
                .memRead    (memRead),
                .memWrite   (memWrite)
        );

        assign instruction = instrMem[pc[7:2]]; // word index
        assign readData    = dataMem[dataAddr[7:2]];

        initial
        begin
                clk = 1'b0;
                forever
                begin
                        #10 clk = ~clk;
                end
        end

        always @(posedge clk)
        begin
                if (!rst && memWrite)
                begin
                        dataMem[dataAddr[7:2]] <= writeData;
                end
        end

        always @(posedge clk)
        begin
                cycleCount <= cycleCount + 1;
        end

        // x^32 + x^22 + x^2 + x + 1
        function automatic logic [31:0] lfsrNext(logic [31:0] s);
                return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
        endfunction

        function automatic logic [31:0] randBits(int count);
                logic [31:0] value;
                value = '0;
                for (int i = 0; i < count; i++)
                begin
                        lfsrState = lfsrNext(lfsrState);
                        value     = {value[30:0], lfsrState[0]};
                end
                return value;
        endfunction

        function automatic logic [4:0] randReg();
                return 5'(randBits(3) % 32'd7) + 5'd1; // r1 to r7
        endfunction

        task automatic failRun(input string msg);
                $display("%s", msg);
                $display("TB FAILED");
                $fatal(1, "simulation stopped after a failed check");
        endtask

        task automatic buildProgram();
                logic [3:0]         kind;
                logic [4:0]         rs;
                logic [4:0]         rt;
                logic [4:0]         rd;
                logic [`DATA_W-1:0] word;
                int                 span;
                int                 hop;
                for (int i = 0; i < PROG_LEN - 1; i++)
                begin
                        kind = 4'(randBits(4));
                        rs   = randReg();
                        rt   = randReg();
                        rd   = randReg();
                        span = PROG_LEN - 1 - i; // targets i+1 up to the last word
                        hop  = int'(randBits(3)) % span;
                        case (kind)
                                4'd0: word = {OP_RTYPE, rs, rt, rd, 5'd0, FN_ADDU};
                                4'd1: word = {OP_RTYPE, rs, rt, rd, 5'd0, FN_SUBU};
                                4'd2: word = {OP_RTYPE, rs, rt, rd, 5'd0, FN_AND};
                                4'd3: word = {OP_RTYPE, rs, rt, rd, 5'd0, FN_OR};
                                4'd4: word = {OP_RTYPE, rs, rt, rd, 5'd0, FN_SLT};
                                4'd5: word = {OP_RTYPE, 5'd0, rt, rd, 5'(randBits(5)), FN_SLL};
                                4'd8,
                                4'd9: word = {OP_LW, 5'd0, rt, 8'd0, 6'(randBits(6)), 2'b00};
                                4'd10,
                                4'd11: word = {OP_SW, 5'd0, rt, 8'd0, 6'(randBits(6)), 2'b00};
                                4'd12: word = {OP_BEQ, rs, rt, 16'(hop)};
                                4'd13: word = {OP_BNE, rs, rt, 16'(hop)};
                                4'd14: word = {OP_J, 26'(i + 1 + hop)};
                                default: word = {OP_ADDIU, rs, rt, 16'(randBits(16))};
                        endcase
                        instrMem[i] = word;
                end
                instrMem[PROG_LEN-1] = {OP_J, 26'(PROG_LEN - 1)}; // spin here
        endtask

        task automatic writeReg(input logic [4:0] idx, input logic [`DATA_W-1:0] value);
                if (idx != 5'd0)
                begin
                        modelRegs[idx] = value;
                end
        endtask

        // ISA-level execution of one instruction
        task automatic stepModel();
                logic [`DATA_W-1:0] ins;
                logic [`DATA_W-1:0] rsVal;
                logic [`DATA_W-1:0] rtVal;
                logic [`DATA_W-1:0] imm;
                logic [`DATA_W-1:0] pcPlus4;
                logic [`DATA_W-1:0] addr;
                ins     = instrMem[modelPc[7:2]];
                rsVal   = modelRegs[ins[`RS_F]];
                rtVal   = modelRegs[ins[`RT_F]];
                imm     = {{16{ins[15]}}, ins[`IMM_F]};
                pcPlus4 = modelPc + 32'd4;
                addr    = rsVal + imm;
                modelPc = pcPlus4;
                case (ins[`OPCODE_F])
                        OP_RTYPE:
                        begin
                                expectedGap = 4;
                                case (ins[`FUNCT_F])
                                        FN_ADDU: writeReg(ins[`RD_F], rsVal + rtVal);
                                        FN_SUBU: writeReg(ins[`RD_F], rsVal - rtVal);
                                        FN_AND:  writeReg(ins[`RD_F], rsVal & rtVal);
                                        FN_OR:   writeReg(ins[`RD_F], rsVal | rtVal);
                                        FN_SLT:  writeReg(ins[`RD_F],
                                                ($signed(rsVal) < $signed(rtVal)) ? 32'd1 : 32'd0);
                                        FN_SLL:  writeReg(ins[`RD_F], rtVal << ins[`SHAMT_F]);
                                        default: failRun(
                                                "the program holds an unknown R-type function");
                                endcase
                        end
                        OP_ADDIU:
                        begin
                                expectedGap = 4;
                                writeReg(ins[`RT_F], rsVal + imm);
                        end
                        OP_LW:
                        begin
                                expectedGap = 5;
                                writeReg(ins[`RT_F], modelMem[addr[7:2]]);
                                loadAddrQ.push_back(addr);
                        end
                        OP_SW:
                        begin
                                expectedGap = 4;
                                modelMem[addr[7:2]] = rtVal;
                                storeAddrQ.push_back(addr);
                                storeDataQ.push_back(rtVal);
                                modelStoreCount++;
                        end
                        OP_BEQ,
                        OP_BNE:
                        begin
                                expectedGap = 3;
                                if ((rsVal == rtVal) == (ins[`OPCODE_F] == OP_BEQ))
                                begin
                                        modelPc = pcPlus4 + (imm << 2);
                                end
                        end
                        OP_J:
                        begin
                                expectedGap = 3;
                                modelPc = {pcPlus4[31:28], ins[`TARGET_F], 2'b00};
                        end
                        default: failRun("the program holds an unknown opcode");
                endcase
        endtask

        task automatic checkResetState();
                assert (pc == `RESET_PC)
                else failRun($sformatf("error at %0t: pc after reset is %h, expected %h",
                        $time, pc, `RESET_PC));
                assert (instrRead && !memRead && !memWrite)
                else failRun($sformatf(
                        "error at %0t: after reset instrRead %b memRead %b memWrite %b",
                        $time, instrRead, memRead, memWrite));
        endtask

        task automatic checkStore();
                assert (storeAddrQ.size() != 0)
                else failRun("the DUT wrote data memory while the model had no store pending");
                assert (dataAddr == storeAddrQ[0] && writeData == storeDataQ[0])
                else failRun($sformatf("error at %0t: store %h to %h, model expects %h to %h",
                        $time, writeData, dataAddr, storeDataQ[0], storeAddrQ[0]));
                void'(storeAddrQ.pop_front());
                void'(storeDataQ.pop_front());
                storeCount++;
        endtask

        task automatic checkLoad();
                assert (loadAddrQ.size() != 0)
                else failRun("the DUT read data memory while the model had no load pending");
                assert (dataAddr == loadAddrQ[0])
                else failRun($sformatf("error at %0t: load from %h, model expects %h",
                        $time, dataAddr, loadAddrQ[0]));
                void'(loadAddrQ.pop_front());
        endtask

        task automatic checkFetch();
                assert (pc == modelPc)
                else failRun($sformatf("error at %0t: fetch from pc %h, model expects %h",
                        $time, pc, modelPc));
                if (fetchCount > 0)
                begin
                        assert (runCycle - lastFetchCycle == expectedGap)
                        else failRun($sformatf(
                                "error at %0t: %0d cycles between fetches, expected %0d",
                                $time, runCycle - lastFetchCycle, expectedGap));
                end
                lastFetchCycle = runCycle;
                fetchCount++;
                if (modelPc == FINAL_PC)
                begin
                        loopFetches++;
                        runDone = (loopFetches >= LOOP_FETCHES);
                end
                stepModel();
        endtask

        task automatic checkCycle();
                runCycle++;
                if (memWrite)
                begin
                        checkStore();
                end
                if (memRead)
                begin
                        checkLoad();
                end
                if (instrRead)
                begin
                        checkFetch();
                end
        endtask

        task automatic checkFinalState();
                assert (storeAddrQ.size() == 0 && storeCount == modelStoreCount)
                else failRun($sformatf("error at %0t: DUT made %0d stores, model made %0d",
                        $time, storeCount, modelStoreCount));
                assert (loadAddrQ.size() == 0)
                else failRun($sformatf("error at %0t: %0d model loads never reached the DUT",
                        $time, loadAddrQ.size()));
                for (int w = 0; w < DATA_WORDS; w++)
                begin
                        assert (dataMem[w] == modelMem[w])
                        else failRun($sformatf("error at %0t: data word %0d is %h, model holds %h",
                                $time, w, dataMem[w], modelMem[w]));
                end
        endtask

        initial
        begin
                rst       = 1'b1;
                lfsrState = SEED;
                modelPc   = `RESET_PC;
                for (int r = 0; r < 32; r++)
                begin
                        modelRegs[r] = '0;
                end
                buildProgram();
                for (int w = 0; w < DATA_WORDS; w++)
                begin
                        dataMem[w]  = randBits(32);
                        modelMem[w] = dataMem[w];
                end
                repeat (RESET_CYCLES) @(posedge clk);
                #1 rst = 1'b0;
                @(negedge clk);
                checkResetState();
                checkCycle();
                while (!runDone && cycleCount < MAX_CYCLES)
                begin
                        @(negedge clk); // outputs settle mid-cycle
                        checkCycle();
                end
                if (runDone)
                begin
                        checkFinalState();
                        $display("TB PASSED");
                        $finish;
                end
                else
                begin
                        failRun($sformatf(
                                "timeout: the CPU did not reach its final loop in %0d cycles",
                                MAX_CYCLES));
                end
        end

endmodule

// ==== build.f ====
+incdir+design
design/cpuPkg.sv
design/regFile.sv
design/aluUnit.sv
design/controlFsm.sv
design/datapath.sv
design/mipsCpu.sv
verif/mipsCpu_checker.sv
verif/mipsCpu_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
        --top-module mipsCpu_tb -f build.f &&
./obj_dir/VmipsCpu_tb | tee /dev/stderr | grep -q "TB PASSED" && exit 0 || exit 1
